// File: verilog/cpu_pkg.sv
/* shared definitions of the RV32I pipeline
   widths, opcodes, ALU op codes, halt constants and the instruction word views */
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // base opcodes kept by this core
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd7;

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

    // ecall halts when a7 holds the exit code
    localparam logic [REG_ADDR_W-1:0] EXIT_REG  = 5'd17;
    localparam logic [XLEN-1:0]       EXIT_CODE = 32'd10;

    // one instruction word, seen as R-format or as I-format fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } inst_t;

endpackage

// File: verilog/pipe_if.sv
/* pipeline register interfaces between the stages
   ID/EX and EX/MEM payloads, plus the forwarding bus from memory and writeback */
`timescale 1ns/1ps

interface id_ex_if import cpu_pkg::*; ();
    logic [XLEN-1:0]       pc, rs1_val, rs2_val, imm;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  funct7_5;
    logic                  alu_src, mem_read, mem_write, mem_to_reg, reg_write;
    logic                  branch, is_jal, is_jalr, pc_to_reg, is_exit;

    modport source (
        output pc, rs1_val, rs2_val, imm, rs1, rs2, rd, opcode, funct3, funct7_5,
        output alu_src, mem_read, mem_write, mem_to_reg, reg_write,
        output branch, is_jal, is_jalr, pc_to_reg, is_exit
    );
    modport sink (
        input pc, rs1_val, rs2_val, imm, rs1, rs2, rd, opcode, funct3, funct7_5,
        input alu_src, mem_read, mem_write, mem_to_reg, reg_write,
        input branch, is_jal, is_jalr, pc_to_reg, is_exit
    );
endinterface

interface ex_mem_if import cpu_pkg::*; ();
    logic [XLEN-1:0]       alu_result, store_data, pc, target;
    logic [REG_ADDR_W-1:0] rd;
    logic                  mem_read, mem_write, mem_to_reg, reg_write, pc_to_reg, is_exit;
    logic                  taken;

    modport source (
        output alu_result, store_data, pc, target, rd,
        output mem_read, mem_write, mem_to_reg, reg_write, pc_to_reg, is_exit, taken
    );
    modport sink (
        input alu_result, store_data, pc, target, rd,
        input mem_read, mem_write, mem_to_reg, reg_write, pc_to_reg, is_exit, taken
    );
endinterface

interface fwd_if import cpu_pkg::*; ();
    logic [REG_ADDR_W-1:0] mem_rd, wb_rd;
    logic                  mem_reg_write, mem_is_load, wb_reg_write;
    logic [XLEN-1:0]       mem_value, wb_value;

    modport source (
        output mem_rd, mem_reg_write, mem_is_load, mem_value, wb_rd, wb_reg_write, wb_value
    );
    modport sink (
        input mem_rd, mem_reg_write, mem_is_load, mem_value, wb_rd, wb_reg_write, wb_value
    );
endinterface

// File: verilog/alu.sv
/* ALU with its own op decode from opcode and funct bits
   also gives the branch condition for beq, bne, blt and bge */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic            funct7_5,
    input  logic [XLEN-1:0] in_a,
    input  logic [XLEN-1:0] in_b,
    output logic [XLEN-1:0] result,
    output logic            cond
);
    logic [ALU_OP_W-1:0] alu_op;
    logic                eq, lt;

    always_comb begin
        alu_op = ALU_ADD; // loads, stores, jalr
        if (opcode == OPC_RTYPE || opcode == OPC_ITYPE) begin
            case (funct3)
                3'b000:  alu_op = (opcode == OPC_RTYPE && funct7_5) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign eq = in_a == in_b;
    assign lt = $signed(in_a) < $signed(in_b);

    always_comb begin
        case (alu_op)
            ALU_SUB: result = in_a - in_b;
            ALU_AND: result = in_a & in_b;
            ALU_OR:  result = in_a | in_b;
            ALU_XOR: result = in_a ^ in_b;
            ALU_SLL: result = in_a << in_b[4:0];
            ALU_SRL: result = in_a >> in_b[4:0];
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lt};
            default: result = in_a + in_b;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  cond = eq;  // beq
            3'b001:  cond = !eq; // bne
            3'b100:  cond = lt;  // blt
            3'b101:  cond = !lt; // bge
            default: cond = 1'b0;
        endcase
    end

endmodule

// File: verilog/register_file.sv
/* 32 x 32 register file, x0 fixed at zero, writeback value bypassed to the reads */
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_rd,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    output logic [XLEN-1:0]       print_reg [32]
);
    logic [XLEN-1:0] regs [32];
    logic            wr_live;

    assign wr_live = wr_en && wr_rd != '0; // x0 never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_live) begin
            regs[wr_rd] <= wr_data;
        end
    end

    assign rs1_data  = (wr_live && wr_rd == rs1) ? wr_data : regs[rs1];
    assign rs2_data  = (wr_live && wr_rd == rs2) ? wr_data : regs[rs2];
    assign print_reg = regs;

endmodule

// File: verilog/fetch_stage.sv
/* fetch stage, program counter, instruction memory and IF/ID register
   always predicts not-taken, redirected from the memory stage */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_load_en,
    input  logic [XLEN-1:0] imem_load_addr,
    input  logic [XLEN-1:0] imem_load_data,
    input  logic            stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] if_inst,
    output logic [XLEN-1:0] if_pc
);
    localparam int IA_W = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;

    always_ff @(posedge clk) begin
        if (imem_load_en)
            imem[imem_load_addr[IA_W-1:0]] <= imem_load_data; // word index
    end

    assign inst = imem[pc[IA_W+1:2]];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            if_inst <= NOP_INST;
            if_pc   <= '0;
        end else if (redirect) begin // wins over stall
            pc      <= redirect_pc;
            if_inst <= NOP_INST;
            if_pc   <= '0;
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_inst <= inst;
            if_pc   <= pc;
        end
    end

endmodule

// File: verilog/decode_stage.sv
/* decode stage, control and immediate decode, load-use and ecall hazards
   reads the register file and loads the ID/EX register */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] if_inst,
    input  logic [XLEN-1:0] if_pc,
    input  logic            redirect,
    output logic            stall,
    fwd_if.sink             fwd,
    id_ex_if.source         id_ex,
    output logic [XLEN-1:0] print_reg [32]
);
    inst_t                 inst;
    logic [6:0]            opcode;
    logic [REG_ADDR_W-1:0] rs1_idx, rs2_idx;
    logic [XLEN-1:0]       rs1_data, rs2_data, x17_val, imm;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_j;
    logic is_rtype, is_itype, is_load, is_store, is_branch, is_jal, is_jalr, is_ecall;
    logic uses_rs2, load_use, exit_wait;

    assign inst   = if_inst;
    assign opcode = inst.r_view.opcode;

    assign is_rtype  = opcode == OPC_RTYPE;
    assign is_itype  = opcode == OPC_ITYPE;
    assign is_load   = opcode == OPC_LOAD;
    assign is_store  = opcode == OPC_STORE;
    assign is_branch = opcode == OPC_BRANCH;
    assign is_jal    = opcode == OPC_JAL;
    assign is_jalr   = opcode == OPC_JALR;
    assign is_ecall  = opcode == OPC_SYSTEM;

    assign rs1_idx = is_ecall ? EXIT_REG : inst.i_view.rs1; // ecall reads a7
    assign rs2_idx = inst.r_view.rs2;

    assign imm_i = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12};
    assign imm_s = {{20{inst.r_view.funct7[6]}}, inst.r_view.funct7, inst.r_view.rd};
    assign imm_b = {{20{inst.r_view.funct7[6]}}, inst.r_view.rd[0],
                    inst.r_view.funct7[5:0], inst.r_view.rd[4:1], 1'b0};
    assign imm_j = {{12{inst.i_view.imm12[11]}}, inst.i_view.rs1, inst.i_view.funct3,
                    inst.i_view.imm12[0], inst.i_view.imm12[10:1], 1'b0};

    always_comb begin
        case (opcode)
            OPC_STORE:  imm = imm_s;
            OPC_BRANCH: imm = imm_b;
            OPC_JAL:    imm = imm_j;
            default:    imm = imm_i;
        endcase
    end

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1_idx),
        .rs2       (rs2_idx),
        .wr_en     (fwd.wb_reg_write),
        .wr_rd     (fwd.wb_rd),
        .wr_data   (fwd.wb_value),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .print_reg (print_reg)
    );

    // a7 from EX/MEM if it is being written there, writeback covered by the bypass
    assign x17_val = (fwd.mem_reg_write && fwd.mem_rd == EXIT_REG) ? fwd.mem_value : rs1_data;

    assign uses_rs2  = is_rtype | is_store | is_branch;
    assign load_use  = id_ex.mem_read && id_ex.rd != '0 &&
                       ((!is_jal && id_ex.rd == rs1_idx) || (uses_rs2 && id_ex.rd == rs2_idx));
    assign exit_wait = is_ecall && ((id_ex.reg_write && id_ex.rd == EXIT_REG) ||
                                    (fwd.mem_is_load && fwd.mem_rd == EXIT_REG));
    assign stall     = load_use | exit_wait;

    // control half of ID/EX, a bubble on stall or flush
    always_ff @(posedge clk) begin
        if (reset || redirect || stall) begin
            id_ex.alu_src    <= 1'b0;
            id_ex.mem_read   <= 1'b0;
            id_ex.mem_write  <= 1'b0;
            id_ex.mem_to_reg <= 1'b0;
            id_ex.reg_write  <= 1'b0;
            id_ex.branch     <= 1'b0;
            id_ex.is_jal     <= 1'b0;
            id_ex.is_jalr    <= 1'b0;
            id_ex.pc_to_reg  <= 1'b0;
            id_ex.is_exit    <= 1'b0;
        end else begin
            id_ex.alu_src    <= is_itype | is_load | is_store | is_jalr;
            id_ex.mem_read   <= is_load;
            id_ex.mem_write  <= is_store;
            id_ex.mem_to_reg <= is_load;
            id_ex.reg_write  <= is_rtype | is_itype | is_load | is_jal | is_jalr;
            id_ex.branch     <= is_branch;
            id_ex.is_jal     <= is_jal;
            id_ex.is_jalr    <= is_jalr;
            id_ex.pc_to_reg  <= is_jal | is_jalr;
            id_ex.is_exit    <= is_ecall && x17_val == EXIT_CODE;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc       <= if_pc;
        id_ex.rs1_val  <= rs1_data;
        id_ex.rs2_val  <= rs2_data;
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1_idx;
        id_ex.rs2      <= rs2_idx;
        id_ex.rd       <= inst.r_view.rd;
        id_ex.opcode   <= opcode;
        id_ex.funct3   <= inst.r_view.funct3;
        id_ex.funct7_5 <= inst.r_view.funct7[5];
    end

endmodule

// File: verilog/execute_stage.sv
/* execute stage, operand forwarding, ALU, branch decision and target
   loads the EX/MEM register */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     redirect,
    id_ex_if.sink    id_ex,
    fwd_if.sink      fwd,
    ex_mem_if.source ex_mem
);
    logic            mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;
    logic [XLEN-1:0] op_a, op_b, alu_b, alu_result;
    logic            cond;

    // nearest producer wins, x0 never forwarded
    assign mem_hit_a = fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == id_ex.rs1;
    assign mem_hit_b = fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == id_ex.rs2;
    assign wb_hit_a  = fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == id_ex.rs1;
    assign wb_hit_b  = fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == id_ex.rs2;

    assign op_a = mem_hit_a ? fwd.mem_value : (wb_hit_a ? fwd.wb_value : id_ex.rs1_val);
    assign op_b = mem_hit_b ? fwd.mem_value : (wb_hit_b ? fwd.wb_value : id_ex.rs2_val);

    assign alu_b = id_ex.alu_src ? id_ex.imm : op_b;

    alu u_alu (
        .opcode   (id_ex.opcode),
        .funct3   (id_ex.funct3),
        .funct7_5 (id_ex.funct7_5),
        .in_a     (op_a),
        .in_b     (alu_b),
        .result   (alu_result),
        .cond     (cond)
    );

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.reg_write  <= 1'b0;
            ex_mem.pc_to_reg  <= 1'b0;
            ex_mem.is_exit    <= 1'b0;
            ex_mem.taken      <= 1'b0;
        end else begin
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.pc_to_reg  <= id_ex.pc_to_reg;
            ex_mem.is_exit    <= id_ex.is_exit;
            ex_mem.taken      <= id_ex.is_jal | id_ex.is_jalr | (id_ex.branch & cond);
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= op_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.pc         <= id_ex.pc;
        ex_mem.target     <= id_ex.is_jalr ? {alu_result[XLEN-1:1], 1'b0}
                                           : id_ex.pc + id_ex.imm;
    end

endmodule

// File: verilog/mem_wb_stage.sv
/* memory and writeback stages, data memory, redirect, MEM/WB register
   and the sticky halt that blocks later writes */
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    ex_mem_if.sink          ex_mem,
    fwd_if.source           fwd,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic            is_halted
);
    localparam int DA_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [XLEN-1:0]       load_data, mem_value;
    logic [XLEN-1:0]       wb_value;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_reg_write;
    logic                  halted;

    assign load_data = dmem[ex_mem.alu_result[DA_W+1:2]]; // asynchronous read

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (ex_mem.mem_write && !halted) begin
            dmem[ex_mem.alu_result[DA_W+1:2]] <= ex_mem.store_data;
        end
    end

    assign redirect    = ex_mem.taken;
    assign redirect_pc = ex_mem.target;

    assign mem_value = ex_mem.pc_to_reg  ? ex_mem.pc + 32'd4 :
                       ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
            halted       <= 1'b0;
        end else begin
            wb_reg_write <= ex_mem.reg_write;
            halted       <= halted | ex_mem.is_exit; // set as the ecall enters MEM/WB
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_mem.rd;
        wb_value <= mem_value;
    end

    assign is_halted = halted;

    assign fwd.mem_rd        = ex_mem.rd;
    assign fwd.mem_reg_write = ex_mem.reg_write;
    assign fwd.mem_is_load   = ex_mem.mem_read;
    assign fwd.mem_value     = mem_value;
    assign fwd.wb_rd         = wb_rd;
    assign fwd.wb_reg_write  = wb_reg_write & ~halted; // nothing retires after halt
    assign fwd.wb_value      = wb_value;

endmodule

// File: verilog/cpu.sv
/* five-stage RV32I pipeline top, wires the stages through their interfaces */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_load_en,
    input  logic [XLEN-1:0] imem_load_addr,
    input  logic [XLEN-1:0] imem_load_data,
    output logic            is_halted,
    output logic [XLEN-1:0] print_reg [32]
);
    logic [XLEN-1:0] if_inst, if_pc, redirect_pc;
    logic            stall, redirect;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    fwd_if    fwd ();

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk            (clk),
        .reset          (reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .if_inst        (if_inst),
        .if_pc          (if_pc)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .if_inst   (if_inst),
        .if_pc     (if_pc),
        .redirect  (redirect),
        .stall     (stall),
        .fwd       (fwd),
        .id_ex     (id_ex),
        .print_reg (print_reg)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .id_ex    (id_ex),
        .fwd      (fwd),
        .ex_mem   (ex_mem)
    );

    mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
        .clk         (clk),
        .reset       (reset),
        .ex_mem      (ex_mem),
        .fwd         (fwd),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .is_halted   (is_halted)
    );

endmodule

// File: bench/cpu_tb_programs.svh
/* directed programs for the pipeline testbench
   instruction encoders and one task per program with its expected registers */
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

localparam logic [6:0]  OP_REG    = 7'b0110011;
localparam logic [6:0]  OP_IMM    = 7'b0010011;
localparam logic [6:0]  OP_LOAD   = 7'b0000011;
localparam logic [6:0]  OP_STORE  = 7'b0100011;
localparam logic [6:0]  OP_BRANCH = 7'b1100011;
localparam logic [6:0]  OP_JAL    = 7'b1101111;
localparam logic [6:0]  OP_JALR   = 7'b1100111;
localparam logic [31:0] ECALL     = 32'h0000_0073;

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [31:0] imm);
    return i_type(OP_IMM, 3'b000, rd, rs1, imm);
endfunction

function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                   input logic [31:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], OP_STORE};
endfunction

// f3: 000 beq, 001 bne, 100 blt, 101 bge
function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

task automatic append_halt();
    prog.push_back(addi(17, 0, 10));  // a7 = exit code
    prog.push_back(ECALL);
endtask

task automatic alu_chain_test();
    logic [31:0] expected [13];
    prog.delete();
    prog.push_back(addi(1, 0, 5));
    prog.push_back(addi(2, 1, 7));
    prog.push_back(r_type(7'h00, 3'b000, 3, 2, 1));  // add x3, x2, x1
    prog.push_back(r_type(7'h20, 3'b000, 4, 3, 1));  // sub, x1 through the decode bypass
    prog.push_back(r_type(7'h00, 3'b001, 5, 4, 2));  // sll x5, x4, x2
    prog.push_back(r_type(7'h00, 3'b100, 6, 5, 3));  // xor x6, x5, x3
    prog.push_back(r_type(7'h00, 3'b110, 7, 6, 4));  // or x7, x6, x4
    prog.push_back(r_type(7'h00, 3'b111, 8, 7, 2));  // and x8, x7, x2
    prog.push_back(r_type(7'h00, 3'b101, 9, 7, 8));  // srl x9, x7, x8
    prog.push_back(addi(10, 0, -3));
    prog.push_back(r_type(7'h00, 3'b010, 11, 10, 9)); // slt x11, x10, x9
    prog.push_back(i_type(OP_IMM, 3'b100, 12, 10, -1)); // xori x12, x10, -1
    prog.push_back(r_type(7'h00, 3'b000, 0, 1, 1));  // add x0 has no effect
    append_halt();
    run_program("dependent ALU chain");
    expected = '{32'h0, 32'd5, 32'd12, 32'd17, 32'd12, 32'h0000_C000, 32'h0000_C011,
                 32'h0000_C01D, 32'hC, 32'hC, 32'hFFFF_FFFD, 32'h1, 32'h2};
    for (int r = 0; r < 13; r++)
        expect_reg(r, expected[r]);
endtask

task automatic load_use_test();
    prog.delete();
    prog.push_back(addi(1, 0, 64));                    // base address
    prog.push_back(addi(2, 0, 1234));
    prog.push_back(sw(2, 1, 8));
    prog.push_back(i_type(OP_LOAD, 3'b010, 3, 1, 8)); // lw x3, 8(x1)
    prog.push_back(addi(4, 3, 100));                   // load-use stall
    prog.push_back(r_type(7'h00, 3'b000, 5, 3, 4));
    prog.push_back(sw(4, 1, 12));
    prog.push_back(i_type(OP_LOAD, 3'b010, 6, 1, 12));
    prog.push_back(r_type(7'h00, 3'b000, 7, 6, 6));
    prog.push_back(i_type(OP_LOAD, 3'b010, 0, 1, 8)); // load into x0
    prog.push_back(r_type(7'h00, 3'b000, 8, 0, 2));
    prog.push_back(i_type(OP_LOAD, 3'b010, 9, 1, 8));
    prog.push_back(sw(9, 1, 16));                      // store data is the fresh load
    prog.push_back(i_type(OP_LOAD, 3'b010, 10, 1, 16));
    append_halt();
    run_program("load-use");
    expect_reg(0, 32'd0);
    expect_reg(3, 32'd1234);
    expect_reg(4, 32'd1334);
    expect_reg(5, 32'd2568);
    expect_reg(6, 32'd1334);
    expect_reg(7, 32'd2668);
    expect_reg(8, 32'd1234);
    expect_reg(10, 32'd1234);
endtask

task automatic control_flow_test();
    prog.delete();
    prog.push_back(addi(1, 0, 7));
    prog.push_back(addi(2, 0, 7));
    prog.push_back(branch(3'b000, 1, 2, 12));  // beq taken to word 5
    prog.push_back(addi(10, 0, 1));
    prog.push_back(addi(10, 0, 2));
    prog.push_back(branch(3'b001, 1, 2, 8));   // bne not taken
    prog.push_back(addi(3, 0, 33));
    prog.push_back(addi(4, 0, -5));
    prog.push_back(branch(3'b100, 4, 1, 8));   // blt taken
    prog.push_back(addi(11, 0, 1));
    prog.push_back(branch(3'b101, 1, 4, 8));   // bge taken
    prog.push_back(addi(12, 0, 1));
    prog.push_back(branch(3'b100, 1, 4, 8));   // blt not taken
    prog.push_back(addi(15, 0, 66));
    prog.push_back(branch(3'b101, 4, 1, 8));   // bge not taken
    prog.push_back(addi(5, 0, 44));
    prog.push_back(jal(6, 12));                // pc 64 to word 19
    prog.push_back(addi(13, 0, 1));
    prog.push_back(addi(13, 0, 2));
    prog.push_back(addi(7, 0, 96));
    prog.push_back(i_type(OP_JALR, 3'b000, 8, 7, 0)); // pc 80 to 96
    prog.push_back(addi(14, 0, 1));
    prog.push_back(addi(14, 0, 2));
    prog.push_back(addi(14, 0, 3));
    prog.push_back(addi(9, 0, 55));
    append_halt();
    run_program("control flow");
    expect_reg(3, 32'd33);
    expect_reg(15, 32'd66);
    expect_reg(5, 32'd44);
    expect_reg(6, 32'd68);
    expect_reg(8, 32'd84);
    expect_reg(9, 32'd55);
    for (int r = 10; r <= 14; r++)
        expect_reg(r, 32'd0); // poison never retires
endtask

task automatic halt_rule_test();
    prog.delete();
    prog.push_back(addi(17, 0, 5));
    prog.push_back(ECALL);                     // a7 = 5, keeps running
    prog.push_back(addi(1, 0, 21));
    prog.push_back(addi(2, 1, 1));
    prog.push_back(addi(17, 0, 10));
    prog.push_back(ECALL);                     // waits on a7, then halts
    prog.push_back(addi(3, 0, 99));
    prog.push_back(addi(1, 0, 99));
    prog.push_back(addi(2, 0, 99));
    run_program("halt rule");
    expect_reg(17, 32'd10);
    expect_reg(1, 32'd21);
    expect_reg(2, 32'd22);
    expect_reg(3, 32'd0);
endtask

task automatic random_imm_test();
    logic [31:0] model [6];
    logic [31:0] imm_a;
    logic [31:0] imm_b;
    for (int r = 0; r < 6; r++)
        model[r] = '0;
    prog.delete();
    for (int round = 0; round < 8; round++) begin
        imm_a = $random(seed);
        imm_b = $random(seed);
        imm_a = {{20{imm_a[11]}}, imm_a[11:0]}; // 12-bit signed immediate
        imm_b = {{20{imm_b[11]}}, imm_b[11:0]};
        prog.push_back(addi(1, 1, imm_a));
        prog.push_back(r_type(7'h00, 3'b000, 2, 2, 1));    // add x2, x2, x1
        prog.push_back(r_type(7'h20, 3'b000, 3, 3, 2));    // sub x3, x3, x2
        prog.push_back(r_type(7'h00, 3'b100, 4, 4, 3));    // xor x4, x4, x3
        prog.push_back(i_type(OP_IMM, 3'b100, 5, 3, imm_b)); // xori x5, x3, imm
        model[1] = model[1] + imm_a;
        model[2] = model[2] + model[1];
        model[3] = model[3] - model[2];
        model[4] = model[4] ^ model[3];
        model[5] = model[3] ^ imm_b;
    end
    append_halt();
    run_program("random immediates");
    for (int r = 1; r < 6; r++)
        expect_reg(r, model[r]);
endtask

`endif

// File: bench/cpu_tb.sv
/* testbench for the five-stage RV32I pipeline
   loads directed programs, runs each to its halt and checks the register view */
`timescale 1ns/1ps

module cpu_tb;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 8; // younger instructions get time to try a write

    // five programs of up to 64 words, one load cycle per word plus up to 4 run cycles each
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        reset;
    logic        imem_load_en;
    logic [31:0] imem_load_addr;
    logic [31:0] imem_load_data;
    logic        is_halted;
    logic [31:0] print_reg [32];

    logic [31:0] prog [$]; // word 0 sits at pc 0
    integer      seed = 32'h4493;
    int          cycle_count = 0;

    cpu #(
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) cpu_i (
        .clk            (clk),
        .reset          (reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .is_halted      (is_halted),
        .print_reg      (print_reg)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the CPU never halted within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_reg(input int idx, input logic [31:0] expected);
        check_value($sformatf("x%0d", idx), print_reg[idx], expected);
    endtask

    // program goes in under reset, then the core runs until it halts
    task automatic run_program(input string name);
        $display("running %s, %0d words", name, prog.size());
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            imem_load_en   <= 1'b1;
            imem_load_addr <= i;
            imem_load_data <= prog[i];
            @(posedge clk);
        end
        imem_load_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("is_halted", {31'b0, is_halted}, 32'h0);
        while (is_halted !== 1'b1)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_value("is_halted", {31'b0, is_halted}, 32'h1); // sticky until reset
    endtask

    `include "cpu_tb_programs.svh"

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;

        alu_chain_test();
        load_use_test();
        control_flow_test();
        halt_rule_test();
        random_imm_test();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+bench
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/alu.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu.sv
bench/cpu_tb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
